//--- Bender.yml
package:
  name: gemac_client

sources:
  - include_dirs:
      - .
    files:
      - ll_pkg.sv
      - mac_ctrl_pkg.sv
      - gemac_client_regs.sv
      - rxmac_to_ll8.sv
      - ll8_to_fifo19.sv
      - fifo19_to_ll8.sv
      - ll8_to_txmac.sv
      - gemac_client_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clk_gen.sv
      - gemac_client_tb.sv

//--- fifo19_to_ll8.sv
//********************
// FIFO words unpacked into link-layer bytes
//********************
`timescale 1ns/100ps
`default_nettype none

module fifo19_to_ll8 (
   input  wire                       sys_clk_i,
   input  wire                       arst_n_i,
   input  wire ll_pkg::f19_word_t    f19_i,
   input  wire                       f19_src_rdy_i,
   output logic                      f19_dst_rdy_o,
   output ll_pkg::ll8_t              ll_o,
   output logic                      ll_src_rdy_o,
   input  wire                       ll_dst_rdy_i
);
   import ll_pkg::*;

   half_e phase_q;
   byte_t upper_byte;
   byte_t lower_byte;
   logic  last_byte;

   assign {upper_byte, lower_byte} = f19_i.data;

   // An odd tail word ends after its upper byte
   assign last_byte = phase_q == LOWER || (f19_i.eof && f19_i.occ);

   assign ll_src_rdy_o  = f19_src_rdy_i;
   assign f19_dst_rdy_o = ll_dst_rdy_i && last_byte;

   always_comb begin
      ll_o.data  = (phase_q == UPPER) ? upper_byte : lower_byte;
      ll_o.sof   = phase_q == UPPER && f19_i.sof;
      ll_o.eof   = f19_i.eof && last_byte;
      ll_o.error = 1'b0;
   end

   always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         phase_q <= UPPER;
      end else if (ll_src_rdy_o && ll_dst_rdy_i) begin
         phase_q <= last_byte ? UPPER : LOWER;
      end
   end

endmodule

`default_nettype wire

//--- gemac_client_macros.svh
//********************
// Register offsets, counter width and FIFO word field widths
//********************
`ifndef GEMAC_CLIENT_MACROS_SVH
`define GEMAC_CLIENT_MACROS_SVH

// Widths
`define GEMAC_CNT_W 32
`define LL_BYTE_W 8
`define F19_DATA_W 16

// Wishbone byte offsets
`define REG_CTRL 8'h00
`define REG_RX_FRAMES 8'h04
`define REG_RX_ERRORS 8'h08
`define REG_TX_FRAMES 8'h0C
`define REG_TX_UNDERRUNS 8'h10

`endif

//--- gemac_client_regs.sv
//********************
// Wishbone control register and statistics counters
//********************
`timescale 1ns/100ps
`default_nettype none
`include "gemac_client_macros.svh"

module gemac_client_regs (
   input  wire                          sys_clk_i,
   input  wire                          arst_n_i,
   input  wire                          wb_cyc_i,
   input  wire                          wb_stb_i,
   input  wire                          wb_we_i,
   input  wire  [7:0]                   wb_adr_i,
   input  wire  [31:0]                  wb_dat_i,
   output logic [31:0]                  wb_dat_o,
   output logic                         wb_ack_o,
   output mac_ctrl_pkg::ctrl_t          ctrl_o,
   input  wire mac_ctrl_pkg::stat_evt_t evt_i
);
   import mac_ctrl_pkg::*;

   ctrl_t       ctrl_q;
   count_t      cnt_q [4];
   logic        req;
   logic        wr;
   logic [3:0]  inc;
   logic [3:0]  clr;
   logic [31:0] rd_data;

   // New cycle only while no ack is out
   assign req    = wb_cyc_i && wb_stb_i && !wb_ack_o;
   assign wr     = req && wb_we_i;
   assign ctrl_o = ctrl_q;

   // Counter order follows the register map
   assign inc = {evt_i.tx_underrun, evt_i.tx_frame, evt_i.rx_error, evt_i.rx_frame};

   always_comb begin
      rd_data = '0;
      clr     = '0;
      case (wb_adr_i)
         `REG_CTRL: rd_data = {30'd0, ctrl_q};
         `REG_RX_FRAMES: begin
            rd_data = cnt_q[0];
            clr[0]  = wr;
         end
         `REG_RX_ERRORS: begin
            rd_data = cnt_q[1];
            clr[1]  = wr;
         end
         `REG_TX_FRAMES: begin
            rd_data = cnt_q[2];
            clr[2]  = wr;
         end
         `REG_TX_UNDERRUNS: begin
            rd_data = cnt_q[3];
            clr[3]  = wr;
         end
         default: rd_data = '0;
      endcase
   end

   always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wb_ack_o <= 1'b0;
         ctrl_q   <= '0;
         for (int i = 0; i < 4; i++) begin
            cnt_q[i] <= '0;
         end
      end else begin
         wb_ack_o <= req;
         if (wr && wb_adr_i == `REG_CTRL) begin
            ctrl_q <= ctrl_t'(wb_dat_i[1:0]);
         end
         // a write wins over an event in the same cycle
         for (int i = 0; i < 4; i++) begin
            if (clr[i]) begin
               cnt_q[i] <= '0;
            end else if (inc[i]) begin
               cnt_q[i] <= cnt_q[i] + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge sys_clk_i) begin
      if (req) begin
         wb_dat_o <= rd_data;
      end
   end

   assert property (@(posedge sys_clk_i) disable iff (!arst_n_i) wb_ack_o |=> !wb_ack_o);

endmodule

`default_nettype wire

//--- gemac_client_tb.sv
//********************
// Directed testbench with MAC model, stream driver and checker
//********************
`timescale 1ns/100ps
`default_nettype none
`include "gemac_client_macros.svh"

module gemac_client_tb;
   import ll_pkg::*;
   import mac_ctrl_pkg::*;

   // Bytes in all test frames, used to size the watchdog
   localparam int FRAME_BYTES = 8 + 7 + 1 + 6 + 5 + 10 + 9 + 10;
   localparam int WATCHDOG_CYCLES = FRAME_BYTES * 20;

   logic        sys_clk;
   logic        arst_n;
   byte_t       rx_data;
   logic        rx_valid;
   logic        rx_last;
   logic        rx_error;
   byte_t       tx_data;
   logic        tx_valid;
   logic        tx_error;
   logic        tx_ack;
   f19_word_t   rx_f19;
   logic        rx_f19_src_rdy;
   logic        rx_f19_dst_rdy;
   f19_word_t   tx_f19;
   logic        tx_f19_src_rdy;
   logic        tx_f19_dst_rdy;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   logic [7:0]  wb_adr;
   logic [31:0] wb_dat_w;
   logic [31:0] wb_dat_r;
   logic        wb_ack;

   byte_t       frame_q[$];
   f19_word_t   word_q[$];
   f19_word_t   rx_words[$];
   byte_t       tx_bytes[$];
   logic [7:0]  lfsr_q = 8'd78;
   logic        mac_busy;
   int          acks_seen;
   int          txerr_pulses;
   string       cur_test;
   int          test_errs;
   int          tests_run;
   int          tests_failed;
   count_t      exp_rx_frames;
   count_t      exp_rx_errors;
   count_t      exp_tx_frames;

   tb_clk_gen clk_gen (
      .clk_o   (sys_clk),
      .arst_n_o(arst_n)
   );

   gemac_client_top DUT (
      .sys_clk_i       (sys_clk),
      .arst_n_i        (arst_n),
      .rx_data_i       (rx_data),
      .rx_valid_i      (rx_valid),
      .rx_last_i       (rx_last),
      .rx_error_i      (rx_error),
      .tx_data_o       (tx_data),
      .tx_valid_o      (tx_valid),
      .tx_error_o      (tx_error),
      .tx_ack_i        (tx_ack),
      .rx_f19_o        (rx_f19),
      .rx_f19_src_rdy_o(rx_f19_src_rdy),
      .rx_f19_dst_rdy_i(rx_f19_dst_rdy),
      .tx_f19_i        (tx_f19),
      .tx_f19_src_rdy_i(tx_f19_src_rdy),
      .tx_f19_dst_rdy_o(tx_f19_dst_rdy),
      .wb_cyc_i        (wb_cyc),
      .wb_stb_i        (wb_stb),
      .wb_we_i         (wb_we),
      .wb_adr_i        (wb_adr),
      .wb_dat_i        (wb_dat_w),
      .wb_dat_o        (wb_dat_r),
      .wb_ack_o        (wb_ack)
   );

   // Taps 8, 6, 5, 4
   function automatic logic [7:0] lfsr_next(input logic [7:0] s);
      return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
   endfunction

   task automatic make_frame(input int len);
      byte_t b;
      frame_q.delete();
      for (int i = 0; i < len; i++) begin
         b = '0;
         for (int k = 0; k < 8; k++) begin
            lfsr_q = lfsr_next(lfsr_q);
            b = {b[6:0], lfsr_q[7]};
         end
         frame_q.push_back(b);
      end
   endtask

   // First byte upper, occ only on a one-byte eof word
   task automatic pack_words();
      f19_word_t w;
      int        n;
      word_q.delete();
      n = frame_q.size();
      for (int i = 0; i < n; i += 2) begin
         w.sof  = (i == 0);
         w.eof  = (i + 2 >= n);
         w.occ  = (i + 1 == n);
         w.data = {frame_q[i], (i + 1 < n) ? frame_q[i+1] : byte_t'(0)};
         word_q.push_back(w);
      end
   endtask

   task automatic start_test(input string name);
      cur_test  = name;
      test_errs = 0;
   endtask

   task automatic finish_test();
      tests_run++;
      if (test_errs == 0) begin
         $display("%s: passed", cur_test);
      end else begin
         tests_failed++;
         $display("%s: failed with %0d errors", cur_test, test_errs);
      end
   endtask

   task automatic fail_check(input string what);
      test_errs++;
      $display("%s: %s", cur_test, what);
   endtask

   task automatic check_byte(input byte_t exp, input byte_t act);
      if (act !== exp) begin
         test_errs++;
         $display("mismatch %s expected %h actual %h", cur_test, exp, act);
      end
   endtask

   task automatic check_word(input f19_word_t exp, input f19_word_t act);
      if (act !== exp) begin
         test_errs++;
         $display("mismatch %s expected %h actual %h", cur_test, exp, act);
      end
   endtask

   task automatic check_count(input count_t exp, input count_t act);
      if (act !== exp) begin
         test_errs++;
         $display("mismatch %s expected %h actual %h", cur_test, exp, act);
      end
   endtask

   task automatic write_reg(input logic [7:0] adr, input logic [31:0] dat);
      int n;
      @(negedge sys_clk);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = 1'b1;
      wb_adr   = adr;
      wb_dat_w = dat;
      n = 0;
      do begin
         @(negedge sys_clk);
         n++;
      end while (!wb_ack && n < 8);
      if (!wb_ack) begin
         fail_check($sformatf("no Wishbone acknowledge on write to %h", adr));
      end
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic read_reg(input logic [7:0] adr, output logic [31:0] dat);
      int n;
      @(negedge sys_clk);
      wb_cyc = 1'b1;
      wb_stb = 1'b1;
      wb_we  = 1'b0;
      wb_adr = adr;
      n = 0;
      do begin
         @(negedge sys_clk);
         n++;
      end while (!wb_ack && n < 8);
      if (!wb_ack) begin
         fail_check($sformatf("no Wishbone acknowledge on read from %h", adr));
      end
      dat    = wb_dat_r;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
   endtask

   task automatic expect_reg(input logic [7:0] adr, input count_t exp);
      logic [31:0] val;
      read_reg(adr, val);
      check_count(exp, count_t'(val));
   endtask

   // MAC side, one byte per cycle, cannot be stalled
   task automatic send_rx_frame(input logic err);
      for (int i = 0; i < frame_q.size(); i++) begin
         @(negedge sys_clk);
         rx_data  = frame_q[i];
         rx_valid = 1'b1;
         rx_last  = (i == frame_q.size() - 1);
         rx_error = err && rx_last;
      end
      @(negedge sys_clk);
      rx_valid = 1'b0;
      rx_last  = 1'b0;
      rx_error = 1'b0;
   endtask

   // Handshake is read just before the edge it completes on
   task automatic drive_words(input int from, input int upto);
      int   n;
      logic taken;
      for (int i = from; i < upto; i++) begin
         @(negedge sys_clk);
         tx_f19         = word_q[i];
         tx_f19_src_rdy = 1'b1;
         n = 0;
         do begin
            @(posedge sys_clk);
            taken = tx_f19_dst_rdy;
            n++;
         end while (!taken && n < 50);
         if (!taken) begin
            fail_check($sformatf("transmit word %0d was never accepted", i));
         end
      end
      @(negedge sys_clk);
      tx_f19_src_rdy = 1'b0;
   endtask

   task automatic test_registers();
      start_test("registers");
      expect_reg(`REG_CTRL, '0);
      write_reg(`REG_CTRL, 32'h3);
      expect_reg(`REG_CTRL, 32'h3);
      expect_reg(`REG_RX_FRAMES, '0);
      expect_reg(`REG_RX_ERRORS, '0);
      expect_reg(`REG_TX_FRAMES, '0);
      expect_reg(`REG_TX_UNDERRUNS, '0);
      expect_reg(8'h14, '0);
      expect_reg(8'h80, '0);
      finish_test();
   endtask

   task automatic test_rx_frame(input string name, input int len, input logic err);
      int n;
      start_test(name);
      make_frame(len);
      pack_words();
      rx_words.delete();
      send_rx_frame(err);
      n = 0;
      while (rx_words.size() < word_q.size() && n < 20) begin
         @(negedge sys_clk);
         n++;
      end
      repeat (4) @(negedge sys_clk);
      if (rx_words.size() != word_q.size()) begin
         fail_check($sformatf("got %0d receive words, wanted %0d",
                              rx_words.size(), word_q.size()));
      end
      for (int i = 0; i < word_q.size() && i < rx_words.size(); i++) begin
         check_word(word_q[i], rx_words[i]);
      end
      exp_rx_frames++;
      if (err) begin
         exp_rx_errors++;
      end
      expect_reg(`REG_RX_FRAMES, exp_rx_frames);
      expect_reg(`REG_RX_ERRORS, exp_rx_errors);
      finish_test();
   endtask

   task automatic test_rx_disabled();
      start_test("rx_disabled");
      write_reg(`REG_CTRL, 32'h1);
      make_frame(5);
      rx_words.delete();
      send_rx_frame(1'b0);
      repeat (10) @(negedge sys_clk);
      if (rx_words.size() != 0) begin
         fail_check("receive words came out while rx_en was clear");
      end
      expect_reg(`REG_RX_FRAMES, exp_rx_frames);
      expect_reg(`REG_RX_ERRORS, exp_rx_errors);
      finish_test();
   endtask

   task automatic test_tx_frame(input string name, input int len);
      int n;
      start_test(name);
      make_frame(len);
      pack_words();
      tx_bytes.delete();
      acks_seen = 0;
      drive_words(0, word_q.size());
      n = 0;
      while (tx_bytes.size() < len && n < 20) begin
         @(negedge sys_clk);
         n++;
      end
      repeat (3) @(negedge sys_clk);
      if (tx_bytes.size() != len) begin
         fail_check($sformatf("MAC got %0d bytes, wanted %0d", tx_bytes.size(), len));
      end
      for (int i = 0; i < len && i < tx_bytes.size(); i++) begin
         check_byte(frame_q[i], tx_bytes[i]);
      end
      if (acks_seen != 1) begin
         fail_check($sformatf("MAC gave %0d start acknowledges", acks_seen));
      end
      exp_tx_frames++;
      expect_reg(`REG_TX_FRAMES, exp_tx_frames);
      finish_test();
   endtask

   // Two words go out, then the source stalls mid-frame
   task automatic test_tx_underrun();
      start_test("tx_underrun");
      make_frame(10);
      pack_words();
      tx_bytes.delete();
      txerr_pulses = 0;
      drive_words(0, 2);
      repeat (3) @(negedge sys_clk);
      drive_words(2, word_q.size());
      repeat (4) @(negedge sys_clk);
      if (txerr_pulses != 1) begin
         fail_check($sformatf("tx_error_o pulsed %0d times", txerr_pulses));
      end
      if (tx_bytes.size() != 4) begin
         fail_check($sformatf("MAC got %0d bytes before the stall", tx_bytes.size()));
      end
      for (int i = 0; i < 4 && i < tx_bytes.size(); i++) begin
         check_byte(frame_q[i], tx_bytes[i]);
      end
      expect_reg(`REG_TX_UNDERRUNS, 32'd1);
      expect_reg(`REG_TX_FRAMES, exp_tx_frames);
      write_reg(`REG_TX_UNDERRUNS, 32'h0);
      expect_reg(`REG_TX_UNDERRUNS, '0);
      finish_test();
   endtask

   // Receive words leave on the next rising edge when both ready lines are high
   always @(negedge sys_clk) begin
      if (arst_n && rx_f19_src_rdy && rx_f19_dst_rdy) begin
         rx_words.push_back(rx_f19);
      end
   end

   // MAC model acks a waiting frame, then takes bytes until tx_valid drops
   initial begin : mac_model
      tx_ack   = 1'b0;
      mac_busy = 1'b0;
      forever begin
         @(negedge sys_clk);
         tx_ack = arst_n && tx_valid && !mac_busy;
         @(posedge sys_clk);
         if (tx_error) begin
            txerr_pulses++;
         end
         if (tx_ack) begin
            tx_bytes.push_back(tx_data);
            acks_seen++;
            mac_busy = 1'b1;
         end else if (mac_busy) begin
            if (tx_valid) begin
               tx_bytes.push_back(tx_data);
            end else begin
               mac_busy = 1'b0;
            end
         end
      end
   end

   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
      $display("timeout after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
      $display("STATUS: FAIL");
      $finish;
   end

   initial begin : main
      rx_data        = '0;
      rx_valid       = 1'b0;
      rx_last        = 1'b0;
      rx_error       = 1'b0;
      rx_f19_dst_rdy = 1'b1;
      tx_f19         = '0;
      tx_f19_src_rdy = 1'b0;
      wb_cyc         = 1'b0;
      wb_stb         = 1'b0;
      wb_we          = 1'b0;
      wb_adr         = '0;
      wb_dat_w       = '0;
      tests_run      = 0;
      tests_failed   = 0;
      exp_rx_frames  = '0;
      exp_rx_errors  = '0;
      exp_tx_frames  = '0;
      @(posedge arst_n);
      @(negedge sys_clk);
      test_registers();
      test_rx_frame("rx_even", 8, 1'b0);
      test_rx_frame("rx_odd", 7, 1'b0);
      test_rx_frame("rx_single", 1, 1'b0);
      test_rx_frame("rx_error", 6, 1'b1);
      test_rx_disabled();
      test_tx_frame("tx_even", 10);
      test_tx_frame("tx_odd", 9);
      test_tx_underrun();
      $display("tests run %0d, passed %0d, failed %0d",
               tests_run, tests_run - tests_failed, tests_failed);
      if (tests_failed == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- gemac_client_top.f
+incdir+.
ll_pkg.sv
mac_ctrl_pkg.sv
gemac_client_regs.sv
rxmac_to_ll8.sv
ll8_to_fifo19.sv
fifo19_to_ll8.sv
ll8_to_txmac.sv
gemac_client_top.sv
tb_clk_gen.sv
gemac_client_tb.sv

//--- gemac_client_top.sv
//********************
// Receive chain, transmit chain and register block
//********************
`timescale 1ns/100ps
`default_nettype none

module gemac_client_top (
   input  wire                      sys_clk_i,
   input  wire                      arst_n_i,
   // MAC side
   input  wire ll_pkg::byte_t       rx_data_i,
   input  wire                      rx_valid_i,
   input  wire                      rx_last_i,
   input  wire                      rx_error_i,
   output ll_pkg::byte_t            tx_data_o,
   output logic                     tx_valid_o,
   output logic                     tx_error_o,
   input  wire                      tx_ack_i,
   // Client FIFO words
   output ll_pkg::f19_word_t        rx_f19_o,
   output logic                     rx_f19_src_rdy_o,
   input  wire                      rx_f19_dst_rdy_i,
   input  wire ll_pkg::f19_word_t   tx_f19_i,
   input  wire                      tx_f19_src_rdy_i,
   output logic                     tx_f19_dst_rdy_o,
   // Wishbone
   input  wire                      wb_cyc_i,
   input  wire                      wb_stb_i,
   input  wire                      wb_we_i,
   input  wire  [7:0]               wb_adr_i,
   input  wire  [31:0]              wb_dat_i,
   output logic [31:0]              wb_dat_o,
   output logic                     wb_ack_o
);
   import ll_pkg::*;
   import mac_ctrl_pkg::*;

   ctrl_t     ctrl;
   stat_evt_t rx_evt;
   stat_evt_t tx_evt;
   stat_evt_t evt;
   ll8_t      rx_ll;
   ll8_t      tx_ll;
   logic      rx_ll_src_rdy;
   logic      rx_ll_dst_rdy;
   logic      tx_ll_src_rdy;
   logic      tx_ll_dst_rdy;

   // Each adapter drives only its own event bits
   assign evt = rx_evt | tx_evt;

   rxmac_to_ll8 rx_adapt (
      .sys_clk_i, .arst_n_i, .ctrl_i(ctrl),
      .rx_data_i, .rx_valid_i, .rx_last_i, .rx_error_i,
      .ll_o(rx_ll), .ll_src_rdy_o(rx_ll_src_rdy), .ll_dst_rdy_i(rx_ll_dst_rdy),
      .rx_evt_o(rx_evt));

   ll8_to_fifo19 rx_pack (
      .sys_clk_i, .arst_n_i,
      .ll_i(rx_ll), .ll_src_rdy_i(rx_ll_src_rdy), .ll_dst_rdy_o(rx_ll_dst_rdy),
      .f19_o(rx_f19_o), .f19_src_rdy_o(rx_f19_src_rdy_o), .f19_dst_rdy_i(rx_f19_dst_rdy_i));

   fifo19_to_ll8 tx_unpack (
      .sys_clk_i, .arst_n_i,
      .f19_i(tx_f19_i), .f19_src_rdy_i(tx_f19_src_rdy_i), .f19_dst_rdy_o(tx_f19_dst_rdy_o),
      .ll_o(tx_ll), .ll_src_rdy_o(tx_ll_src_rdy), .ll_dst_rdy_i(tx_ll_dst_rdy));

   ll8_to_txmac tx_adapt (
      .sys_clk_i, .arst_n_i, .ctrl_i(ctrl),
      .ll_i(tx_ll), .ll_src_rdy_i(tx_ll_src_rdy), .ll_dst_rdy_o(tx_ll_dst_rdy),
      .tx_data_o, .tx_valid_o, .tx_error_o, .tx_ack_i,
      .tx_evt_o(tx_evt));

   gemac_client_regs regs (
      .sys_clk_i, .arst_n_i,
      .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_dat_o, .wb_ack_o,
      .ctrl_o(ctrl), .evt_i(evt));

endmodule

`default_nettype wire

//--- ll8_to_fifo19.sv
//********************
// Link-layer bytes packed into two-byte FIFO words
//********************
`timescale 1ns/100ps
`default_nettype none

module ll8_to_fifo19 (
   input  wire                    sys_clk_i,
   input  wire                    arst_n_i,
   input  wire ll_pkg::ll8_t      ll_i,
   input  wire                    ll_src_rdy_i,
   output logic                   ll_dst_rdy_o,
   output ll_pkg::f19_word_t      f19_o,
   output logic                   f19_src_rdy_o,
   input  wire                    f19_dst_rdy_i
);
   import ll_pkg::*;

   half_e phase_q;
   byte_t hold_q;
   logic  hold_sof_q;
   logic  take;
   logic  word_load;

   // Output word can be refilled in the cycle it is taken
   assign ll_dst_rdy_o = !f19_src_rdy_o || f19_dst_rdy_i;
   assign take         = ll_src_rdy_i && ll_dst_rdy_o;
   assign word_load    = take && (phase_q == LOWER || ll_i.eof);

   always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         phase_q       <= UPPER;
         f19_src_rdy_o <= 1'b0;
      end else begin
         if (take) begin
            phase_q <= (phase_q == UPPER && !ll_i.eof) ? LOWER : UPPER;
         end
         if (word_load) begin
            f19_src_rdy_o <= 1'b1;
         end else if (f19_dst_rdy_i) begin
            f19_src_rdy_o <= 1'b0;
         end
      end
   end

   always_ff @(posedge sys_clk_i) begin
      if (take && phase_q == UPPER) begin
         hold_q     <= ll_i.data;
         hold_sof_q <= ll_i.sof;
      end
      if (word_load) begin
         if (phase_q == UPPER) begin
            // Odd tail, lower half left zero
            f19_o.occ  <= 1'b1;
            f19_o.eof  <= 1'b1;
            f19_o.sof  <= ll_i.sof;
            f19_o.data <= {ll_i.data, byte_t'(0)};
         end else begin
            f19_o.occ  <= 1'b0;
            f19_o.eof  <= ll_i.eof;
            f19_o.sof  <= hold_sof_q;
            f19_o.data <= {hold_q, ll_i.data};
         end
      end
   end

   // A one-byte frame must start a new word
   assert property (@(posedge sys_clk_i) disable iff (!arst_n_i)
      take && phase_q == LOWER |-> !(ll_i.sof && ll_i.eof));

endmodule

`default_nettype wire

//--- ll8_to_txmac.sv
//********************
// Link-layer bytes to MAC transmit with underrun detect
//********************
`timescale 1ns/100ps
`default_nettype none

module ll8_to_txmac (
   input  wire                       sys_clk_i,
   input  wire                       arst_n_i,
   input  wire mac_ctrl_pkg::ctrl_t  ctrl_i,
   input  wire ll_pkg::ll8_t         ll_i,
   input  wire                       ll_src_rdy_i,
   output logic                      ll_dst_rdy_o,
   output ll_pkg::byte_t             tx_data_o,
   output logic                      tx_valid_o,
   output logic                      tx_error_o,
   input  wire                       tx_ack_i,
   output mac_ctrl_pkg::stat_evt_t   tx_evt_o
);
   import mac_ctrl_pkg::*;

   typedef enum logic [2:0] {
      IDLE,
      WAIT_ACK,
      SEND,
      UNDERRUN,
      FLUSH
   } state_e;

   state_e    state_q;
   state_e    state_d;
   stat_evt_t evt_d;

   always_comb begin
      state_d      = state_q;
      ll_dst_rdy_o = 1'b0;
      evt_d        = '0;
      case (state_q)
         IDLE: begin
            // Stray bytes ahead of a sof are thrown away
            ll_dst_rdy_o = !ll_i.sof;
            if (ll_src_rdy_i && ll_i.sof && ctrl_i.tx_en) begin
               state_d = WAIT_ACK;
            end
         end
         WAIT_ACK: begin
            ll_dst_rdy_o = tx_ack_i;
            if (tx_ack_i) begin
               state_d        = ll_i.eof ? IDLE : SEND;
               evt_d.tx_frame = ll_i.eof;
            end
         end
         SEND: begin
            ll_dst_rdy_o = 1'b1;
            if (!ll_src_rdy_i) begin
               state_d           = UNDERRUN;
               evt_d.tx_underrun = 1'b1;
            end else if (ll_i.eof) begin
               state_d        = IDLE;
               evt_d.tx_frame = 1'b1;
            end
         end
         UNDERRUN: state_d = FLUSH;
         FLUSH: begin
            ll_dst_rdy_o = 1'b1;
            if (ll_src_rdy_i && ll_i.eof) begin
               state_d = IDLE;
            end
         end
         default: state_d = IDLE;
      endcase
   end

   // First byte is held on the bus until the MAC acks it
   assign tx_data_o  = ll_i.data;
   assign tx_valid_o = state_q == WAIT_ACK || (state_q == SEND && ll_src_rdy_i);
   assign tx_error_o = state_q == UNDERRUN;

   always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q  <= IDLE;
         tx_evt_o <= '0;
      end else begin
         state_q  <= state_d;
         tx_evt_o <= evt_d;
      end
   end

   assert property (@(posedge sys_clk_i) disable iff (!arst_n_i) tx_ack_i |-> tx_valid_o);

endmodule

`default_nettype wire

//--- ll_pkg.sv
//********************
// Link-layer byte and FIFO word types
//********************
`default_nettype none
`include "gemac_client_macros.svh"

package ll_pkg;

   typedef logic [`LL_BYTE_W-1:0] byte_t;

   typedef logic [`F19_DATA_W-1:0] f19_data_t;

   // One byte on the link-layer stream
   typedef struct packed {
      byte_t data;
      logic  sof;
      logic  eof;
      logic  error;
   } ll8_t;

   // Two bytes per word, first byte in the upper half
   typedef struct packed {
      logic      occ;
      logic      eof;
      logic      sof;
      f19_data_t data;
   } f19_word_t;

   // Which half of a FIFO word is being handled
   typedef enum logic {
      UPPER,
      LOWER
   } half_e;

endpackage

`default_nettype wire

//--- mac_ctrl_pkg.sv
//********************
// Control and statistics types
//********************
`default_nettype none
`include "gemac_client_macros.svh"

package mac_ctrl_pkg;

   // Control register, bit 1 rx_en and bit 0 tx_en
   typedef struct packed {
      logic rx_en;
      logic tx_en;
   } ctrl_t;

   // Single-cycle pulses from the MAC adapters
   typedef struct packed {
      logic rx_frame;
      logic rx_error;
      logic tx_frame;
      logic tx_underrun;
   } stat_evt_t;

   typedef logic [`GEMAC_CNT_W-1:0] count_t;

endpackage

`default_nettype wire

//--- rxmac_to_ll8.sv
//********************
// MAC receive bytes to link-layer stream
//********************
`timescale 1ns/100ps
`default_nettype none

module rxmac_to_ll8 (
   input  wire                          sys_clk_i,
   input  wire                          arst_n_i,
   input  wire mac_ctrl_pkg::ctrl_t     ctrl_i,
   input  wire ll_pkg::byte_t           rx_data_i,
   input  wire                          rx_valid_i,
   input  wire                          rx_last_i,
   input  wire                          rx_error_i,
   output ll_pkg::ll8_t                 ll_o,
   output logic                         ll_src_rdy_o,
   input  wire                          ll_dst_rdy_i,
   output mac_ctrl_pkg::stat_evt_t      rx_evt_o
);
   import mac_ctrl_pkg::*;

   typedef enum logic [1:0] {
      IDLE,
      FRAME,
      DROP
   } state_e;

   state_e    state_q;
   state_e    state_d;
   stat_evt_t evt_d;
   logic      space;
   logic      load;
   logic      patch;
   logic      first;
   logic      ovr_q;

   // Output register is free when empty or being drained
   assign space = !ll_src_rdy_o || ll_dst_rdy_i;

   always_comb begin
      state_d = state_q;
      load    = 1'b0;
      patch   = 1'b0;
      first   = 1'b0;
      evt_d   = '0;
      case (state_q)
         IDLE: begin
            if (rx_valid_i) begin
               if (ctrl_i.rx_en && space) begin
                  load  = 1'b1;
                  first = 1'b1;
               end else begin
                  // Frame lost for lack of room is still counted
                  evt_d.rx_error = ctrl_i.rx_en;
               end
               if (!rx_last_i) begin
                  state_d = (ctrl_i.rx_en && space) ? FRAME : DROP;
               end
            end
         end
         FRAME: begin
            if (rx_valid_i) begin
               load  = space;
               patch = !space && rx_last_i;
               if (rx_last_i) begin
                  state_d = IDLE;
               end
            end
         end
         DROP: begin
            if (rx_valid_i && rx_last_i) begin
               state_d = IDLE;
            end
         end
         default: state_d = IDLE;
      endcase
      if ((load || patch) && rx_last_i) begin
         evt_d.rx_frame = 1'b1;
         evt_d.rx_error = rx_error_i || ovr_q || patch;
      end
   end

   always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q      <= IDLE;
         ll_src_rdy_o <= 1'b0;
         ovr_q        <= 1'b0;
         rx_evt_o     <= '0;
      end else begin
         state_q  <= state_d;
         rx_evt_o <= evt_d;
         if (load) begin
            ll_src_rdy_o <= 1'b1;
         end else if (ll_dst_rdy_i) begin
            ll_src_rdy_o <= 1'b0;
         end
         // Sticky until the frame ends
         if (state_d == IDLE) begin
            ovr_q <= 1'b0;
         end else if (state_q == FRAME && rx_valid_i && !space) begin
            ovr_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge sys_clk_i) begin
      if (load) begin
         ll_o.data  <= rx_data_i;
         ll_o.sof   <= first;
         ll_o.eof   <= rx_last_i;
         ll_o.error <= rx_last_i && (rx_error_i || ovr_q);
      end else if (patch) begin
         // last byte was lost, the held byte closes the frame
         ll_o.eof   <= 1'b1;
         ll_o.error <= 1'b1;
      end
   end

   assert property (@(posedge sys_clk_i) disable iff (!arst_n_i) rx_last_i |-> rx_valid_i);

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
//********************
// Testbench clock and reset
//********************
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
   output logic clk_o,
   output logic arst_n_o
);
   localparam time HALF_PERIOD = 50ns;

   initial begin
      clk_o = 1'b0;
      forever begin
         #HALF_PERIOD clk_o = ~clk_o;
      end
   end

   // Reset held for two rising edges, released on a falling edge
   initial begin
      arst_n_o = 1'b0;
      repeat (2) @(posedge clk_o);
      @(negedge clk_o);
      arst_n_o = 1'b1;
   end

endmodule

`default_nettype wire
